// File: src.f
hw/cache_parameters.sv
hw/axi4lite_parameters.sv
hw/cache_ctrl_if.sv
hw/cache_way.sv
hw/cache_datapath.sv
hw/cache_controller.sv
hw/cache.sv
verification/axi4lite_memory_model.sv
verification/cache_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = cache_tb
RTL_TOP   = cache
FILELIST  = src.f
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

obj_dir/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: verification/cache_tb.sv
// Cache testbench
// Runs reads, writes and an LRU replacement sequence through the cache
// against the AXI4-Lite memory model and checks data, latency and traffic

`timescale 1ns/1ps

module cache_tb
    import cache_parameters::*;
    import axi4lite_parameters::*;
();

    localparam int LIMIT = 200;

    logic        clk;
    logic        reset;
    logic        req;
    logic        write;
    cache_addr_t addr;
    cache_word_t w_data;
    logic        ready;
    logic        valid;
    cache_word_t r_data;
    axi_addr_t   araddr;
    axi_addr_t   awaddr;
    axi_data_t   rdata;
    axi_data_t   wdata;
    logic        arvalid;
    logic        arready;
    logic        rvalid;
    logic        rready;
    logic        awvalid;
    logic        awready;
    logic        wvalid;
    logic        wready;
    logic        bvalid;
    logic        bready;

    cache_word_t mirror [cache_addr_t];
    int          value_errors;
    int          protocol_errors;
    int          ar_count;
    int          aw_count;
    int          w_count;
    int          b_count;
    axi_addr_t   last_araddr;
    axi_addr_t   last_awaddr;
    axi_data_t   last_wdata;

    cache UUT (.*);

    axi4lite_memory_model memory (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Handshakes are counted at the falling edge ahead of the edge that takes them
    always @(negedge clk) begin
        if (arvalid && arready) begin
            ar_count++;
            last_araddr = araddr;
        end
        if (awvalid && awready) begin
            aw_count++;
            last_awaddr = awaddr;
        end
        if (wvalid && wready) begin
            w_count++;
            last_wdata = wdata;
        end
        if (bvalid && bready) b_count++;
    end

    araddr_stable: assert property (@(posedge clk) disable iff (reset)
        (arvalid && !arready) |=> $stable(araddr))
        else begin
            protocol_errors++;
            $display("CHECK FAILED araddr moved under back-pressure, now 0x%08h", araddr);
        end

    awaddr_stable: assert property (@(posedge clk) disable iff (reset)
        (awvalid && !awready) |=> $stable(awaddr))
        else begin
            protocol_errors++;
            $display("CHECK FAILED awaddr moved under back-pressure, now 0x%08h", awaddr);
        end

    wdata_stable: assert property (@(posedge clk) disable iff (reset)
        (wvalid && !wready) |=> $stable(wdata))
        else begin
            protocol_errors++;
            $display("CHECK FAILED wdata moved under back-pressure, now 0x%08h", wdata);
        end

    function automatic cache_word_t expected_word(input cache_addr_t a);
        cache_addr_t w;
        w = {a[31:2], 2'b00};
        if (mirror.exists(w)) return mirror[w];
        return w ^ {w[15:0], w[31:16]} ^ 32'h3c5a_96e1;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            value_errors++;
            $display("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_rule(input logic ok, input string what);
        assert (ok) else begin
            protocol_errors++;
            $display("Protocol check failed: %s", what);
        end
    endtask

    // hit_mode 1 expects a hit, 0 a miss
    task automatic access(input logic wr, input cache_addr_t a, input cache_word_t d,
                          input logic hit_mode);
        int n;
        int latency;
        @(posedge clk);
        #1;
        req    = 1'b1;
        write  = wr;
        addr   = a;
        w_data = d;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n == LIMIT) begin
                $display("Timeout: the cache never became ready");
                $display("RESULT: FAIL");
                $finish;
            end
        end while (!ready);
        @(posedge clk);
        {ar_count, aw_count, w_count, b_count} = '0;
        #1 req = 1'b0;
        latency = 0;
        do begin
            @(negedge clk);
            latency++;
            if (latency == LIMIT) begin
                $display("Timeout: no valid after an accepted request");
                $display("RESULT: FAIL");
                $finish;
            end
        end while (!valid);
        if (wr) begin
            check_rule(aw_count == 1 && w_count == 1, "write needs one address and one data beat");
            check_rule(b_count == 1, "write finished before its response");
            check_value("awaddr", last_awaddr, {a[31:2], 2'b00});
            check_value("wdata", last_wdata, d);
            mirror[{a[31:2], 2'b00}] = d;
        end else begin
            check_value("r_data", r_data, expected_word(a));
            if (hit_mode) begin
                check_rule(ar_count == 0, "read hit went to memory");
                check_rule(latency == 2, "read hit did not answer in two cycles");
            end else begin
                check_rule(ar_count == 1, "read miss needs exactly one memory read");
                check_value("araddr", last_araddr, {a[31:2], 2'b00});
            end
        end
    endtask

    initial begin
        {req, write, addr, w_data} = '0;
        {value_errors, protocol_errors} = '0;
        reset = 1'b1;
        repeat (2) begin
            @(posedge clk);
            #1;
            check_rule(!(valid || arvalid || awvalid || wvalid || rready || bready),
                       "strobe high during reset");
        end
        reset = 1'b0;
        @(negedge clk);
        check_rule(ready, "ready low after reset");
        check_rule(!(valid || arvalid || awvalid || wvalid || rready || bready),
                   "strobe high after reset");

        access(1'b0, 32'h0000_0044, '0, 1'b0);
        access(1'b0, 32'h0000_0046, '0, 1'b1);                      // Same word, other byte

        // A, B and C share set 0
        access(1'b0, 32'h0000_0100, '0, 1'b0);
        access(1'b0, 32'h0000_1100, '0, 1'b0);
        access(1'b0, 32'h0000_0100, '0, 1'b1);
        access(1'b0, 32'h0000_2100, '0, 1'b0);
        access(1'b0, 32'h0000_0100, '0, 1'b1);
        access(1'b0, 32'h0000_1100, '0, 1'b0);

        access(1'b1, 32'h0000_0100, 32'hdead_beef, 1'b1);
        access(1'b0, 32'h0000_0100, '0, 1'b1);
        access(1'b1, 32'h0000_3048, 32'h1234_5678, 1'b0);
        access(1'b0, 32'h0000_3048, '0, 1'b0);                      // No allocate on write
        access(1'b0, 32'h0000_3048, '0, 1'b1);

        repeat (3) @(posedge clk);
        $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: verification/axi4lite_memory_model.sv
// AXI4-Lite memory model
// Word-addressed slave memory for the cache testbench. Every ready is
// delayed by 0 to 3 cycles drawn from an xorshift generator, and unwritten
// words read back as a pattern of their full address

`timescale 1ns/1ps

module axi4lite_memory_model
    import axi4lite_parameters::*;
(
    input  logic      clk,
    input  logic      reset,
    input  axi_addr_t araddr,
    input  logic      arvalid,
    output logic      arready,
    output axi_data_t rdata,
    output logic      rvalid,
    input  logic      rready,
    input  axi_addr_t awaddr,
    input  logic      awvalid,
    output logic      awready,
    input  axi_data_t wdata,
    input  logic      wvalid,
    output logic      wready,
    output logic      bvalid,
    input  logic      bready
);

    axi_data_t   mem [axi_addr_t];
    logic [31:0] rng;
    logic [1:0]  ar_wait;
    logic [1:0]  aw_wait;
    logic [1:0]  w_wait;
    logic        aw_seen;
    logic        w_seen;
    axi_addr_t   aw_addr_q;
    axi_data_t   w_data_q;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic axi_data_t lookup(input axi_addr_t a);
        if (mem.exists(a)) return mem[a];
        return a ^ {a[15:0], a[31:16]} ^ 32'h3c5a_96e1;          // Preload pattern
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            rng = 32'hf414_b5d7;
            {arready, rvalid, awready, wready, bvalid} <= '0;
            {ar_wait, aw_wait, w_wait} <= '0;
            {aw_seen, w_seen} <= '0;
            rdata <= '0;
        end else begin
            arready <= 1'b0;
            awready <= 1'b0;
            wready  <= 1'b0;
            if (rvalid && rready) rvalid <= 1'b0;
            if (bvalid && bready) bvalid <= 1'b0;

            if (arvalid && arready) begin
                rdata   <= lookup(araddr);
                rvalid  <= 1'b1;
                rng = xorshift(rng);
                ar_wait <= rng[1:0];
            end else if (arvalid && !rvalid) begin
                if (ar_wait == 0) arready <= 1'b1;
                else ar_wait <= ar_wait - 1'b1;
            end

            if (awvalid && awready) begin
                aw_seen   <= 1'b1;
                aw_addr_q <= awaddr;
                rng = xorshift(rng);
                aw_wait   <= rng[1:0];
            end else if (awvalid && !aw_seen) begin
                if (aw_wait == 0) awready <= 1'b1;
                else aw_wait <= aw_wait - 1'b1;
            end

            if (wvalid && wready) begin
                w_seen   <= 1'b1;
                w_data_q <= wdata;
                rng = xorshift(rng);
                w_wait   <= rng[1:0];
            end else if (wvalid && !w_seen) begin
                if (w_wait == 0) wready <= 1'b1;
                else w_wait <= w_wait - 1'b1;
            end

            // Both halves of the write are in, so commit and answer
            if (aw_seen && w_seen && !bvalid) begin
                mem[aw_addr_q] = w_data_q;
                bvalid  <= 1'b1;
                aw_seen <= 1'b0;
                w_seen  <= 1'b0;
            end
        end
    end

endmodule

// File: hw/cache.sv
// Two-way set-associative data cache
// Read-allocate, write-through, no-write-allocate cache between a processor
// request port and an AXI4-Lite memory port. The controller drives every
// strobe and the datapath drives addresses and data

`timescale 1ns/1ps

module cache
    import cache_parameters::*;
    import axi4lite_parameters::*;
(
    input  logic        clk,
    input  logic        reset,

    // Processor side
    input  logic        req,
    input  logic        write,
    input  cache_addr_t addr,
    input  cache_word_t w_data,
    output logic        ready,
    output logic        valid,
    output cache_word_t r_data,

    // AXI4-Lite memory side
    output axi_addr_t   araddr,
    output logic        arvalid,
    input  logic        arready,
    input  axi_data_t   rdata,
    input  logic        rvalid,
    output logic        rready,
    output axi_addr_t   awaddr,
    output logic        awvalid,
    input  logic        awready,
    output axi_data_t   wdata,
    output logic        wvalid,
    input  logic        wready,
    input  logic        bvalid,
    output logic        bready
);

    cache_ctrl_if ctrl_link ();

    cache_controller ctrl (
        .clk     (clk),
        .reset   (reset),
        .req     (req),
        .arready (arready),
        .rvalid  (rvalid),
        .awready (awready),
        .wready  (wready),
        .bvalid  (bvalid),
        .ctrl    (ctrl_link.controller),
        .ready   (ready),
        .valid   (valid),
        .arvalid (arvalid),
        .rready  (rready),
        .awvalid (awvalid),
        .wvalid  (wvalid),
        .bready  (bready)
    );

    cache_datapath dp (
        .clk    (clk),
        .reset  (reset),
        .write  (write),
        .addr   (addr),
        .w_data (w_data),
        .rdata  (rdata),
        .ctrl   (ctrl_link.datapath),
        .r_data (r_data),
        .araddr (araddr),
        .awaddr (awaddr),
        .wdata  (wdata)
    );

endmodule

// File: hw/cache_controller.sv
// Cache controller
// FSM that accepts processor requests, steers the lookup, fetches missed
// words and writes every store through to memory. It owns all ready and
// valid strobes on both the processor and the AXI4-Lite side

`timescale 1ns/1ps

module cache_controller
    import cache_parameters::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   req,
    input  logic                   arready,
    input  logic                   rvalid,
    input  logic                   awready,
    input  logic                   wready,
    input  logic                   bvalid,
    cache_ctrl_if.controller       ctrl,
    output logic                   ready,
    output logic                   valid,
    output logic                   arvalid,
    output logic                   rready,
    output logic                   awvalid,
    output logic                   wvalid,
    output logic                   bready
);

    cache_state_e state_q;
    cache_state_e state_d;
    logic         aw_done_q;                                        // Write address already taken
    logic         w_done_q;                                         // Write data already taken
    logic         aw_ok;
    logic         w_ok;

    assign aw_ok = aw_done_q || awready;
    assign w_ok  = w_done_q || wready;

    always_comb begin
        state_d          = state_q;
        ready            = 1'b0;
        valid            = 1'b0;
        arvalid          = 1'b0;
        rready           = 1'b0;
        awvalid          = 1'b0;
        wvalid           = 1'b0;
        bready           = 1'b0;
        ctrl.capture_req = 1'b0;
        ctrl.fill_en     = 1'b0;
        ctrl.update_en   = 1'b0;
        ctrl.lru_touch   = 1'b0;

        case (state_q)
            IDLE: begin
                ready = 1'b1;
                if (req) begin
                    ctrl.capture_req = 1'b1;
                    state_d          = COMPARE;
                end
            end
            COMPARE: begin
                if (ctrl.req_write) begin
                    // Write-through, and a hit also refreshes the stored line
                    ctrl.update_en = ctrl.hit;
                    ctrl.lru_touch = ctrl.hit;
                    state_d        = WRITE_REQ;
                end else if (ctrl.hit) begin
                    ctrl.lru_touch = 1'b1;
                    state_d        = RESPOND;
                end else begin
                    state_d = READ_ADDR;
                end
            end
            READ_ADDR: begin
                arvalid = 1'b1;
                if (arready) state_d = READ_DATA;
            end
            READ_DATA: begin
                rready = 1'b1;
                if (rvalid) begin
                    ctrl.fill_en   = 1'b1;                          // Fill lands on the rvalid edge
                    ctrl.lru_touch = 1'b1;
                    state_d        = RESPOND;
                end
            end
            WRITE_REQ: begin
                awvalid = !aw_done_q;
                wvalid  = !w_done_q;
                if (aw_ok && w_ok) state_d = WRITE_RESP;
            end
            WRITE_RESP: begin
                bready = 1'b1;
                if (bvalid) state_d = RESPOND;
            end
            RESPOND: begin
                valid   = 1'b1;
                state_d = IDLE;
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // The two write channels may complete in either order
    always_ff @(posedge clk) begin
        if (reset || state_d != WRITE_REQ) begin
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
        end else begin
            if (awvalid && awready) aw_done_q <= 1'b1;
            if (wvalid && wready) w_done_q <= 1'b1;
        end
    end

    no_valid_while_ready: assert property (
        @(posedge clk) disable iff (reset) !(valid && ready)
    );

    arvalid_held_until_arready: assert property (
        @(posedge clk) disable iff (reset) (arvalid && !arready) |=> arvalid
    );

    fill_update_exclusive: assert property (
        @(posedge clk) disable iff (reset) !(ctrl.fill_en && ctrl.update_en)
    );

endmodule

// File: hw/cache_datapath.sv
// Cache datapath
// Holds the accepted request, looks it up in both ways, chooses the victim
// from the valid and LRU bits and drives the read data and the AXI
// address and write data

`timescale 1ns/1ps

module cache_datapath
    import cache_parameters::*;
    import axi4lite_parameters::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 write,
    input  cache_addr_t          addr,
    input  cache_word_t          w_data,
    input  axi_data_t            rdata,
    cache_ctrl_if.datapath       ctrl,
    output cache_word_t          r_data,
    output axi_addr_t            araddr,
    output axi_addr_t            awaddr,
    output axi_data_t            wdata
);

    cache_addr_t         req_addr_q;
    cache_word_t         req_wdata_q;
    logic                req_write_q;
    cache_tag_t          req_tag;
    cache_index_t        req_index;
    way_sel_t            way_hit;
    way_sel_t            way_valid;
    way_sel_t            victim;
    way_sel_t            touched;
    cache_word_t         way_rdata [NUM_WAYS];
    cache_word_t         way_wdata;
    cache_word_t         hit_word;
    cache_word_t         fill_word_q;
    logic                use_fill_q;
    logic [NUM_SETS-1:0] lru_q;                                     // Index of the LRU way per set

    always_ff @(posedge clk) begin
        if (ctrl.capture_req) begin
            req_addr_q  <= addr;
            req_wdata_q <= w_data;
            req_write_q <= write;
        end
    end

    assign req_tag   = req_addr_q[ADDR_BITS-1 -: TAG_BITS];
    assign req_index = req_addr_q[OFFSET_BITS +: INDEX_BITS];
    assign way_wdata = ctrl.fill_en ? rdata : req_wdata_q;

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        cache_way u_way (
            .clk        (clk),
            .reset      (reset),
            .index      (req_index),
            .tag        (req_tag),
            .write_word (way_wdata),
            .fill       (ctrl.fill_en & victim[w]),
            .update     (ctrl.update_en & ctrl.hit_way[w]),
            .hit        (way_hit[w]),
            .read_word  (way_rdata[w]),
            .valid_line (way_valid[w])
        );
    end

    assign ctrl.hit       = |way_hit;
    assign ctrl.hit_way   = way_hit;
    assign ctrl.req_write = req_write_q;

    // Lowest invalid way first, otherwise the least recently used one
    always_comb begin
        victim = '0;
        for (int i = NUM_WAYS - 1; i >= 0; i--) begin
            if (!way_valid[i]) victim = way_sel_t'(1) << i;
        end
        if (victim == '0) victim = way_sel_t'(1) << lru_q[req_index];
    end

    assign touched = ctrl.fill_en ? victim : ctrl.hit_way;

    // With two ways the LRU one is simply the way not touched last
    always_ff @(posedge clk) begin
        if (reset) begin
            lru_q <= '0;
        end else if (ctrl.lru_touch) begin
            lru_q[req_index] <= touched[0];
        end
    end

    // Keep the fetched word so a miss answers from it
    always_ff @(posedge clk) begin
        if (reset) begin
            use_fill_q <= 1'b0;
        end else if (ctrl.capture_req) begin
            use_fill_q <= 1'b0;
        end else if (ctrl.fill_en) begin
            use_fill_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.fill_en) fill_word_q <= rdata;
    end

    always_comb begin
        hit_word = '0;
        for (int i = 0; i < NUM_WAYS; i++) begin
            if (ctrl.hit_way[i]) hit_word = way_rdata[i];
        end
    end

    assign r_data = use_fill_q ? fill_word_q : hit_word;
    assign araddr = {req_addr_q[ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    assign awaddr = {req_addr_q[ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    assign wdata  = req_wdata_q;

    // A tag lives in at most one way of a set, so fills never duplicate a line
    hit_way_onehot: assert property (
        @(posedge clk) disable iff (reset) $onehot0(ctrl.hit_way)
    );

endmodule

// File: hw/cache_way.sv
// Cache way
// Valid bits, tags and data words of one way, one line per set.
// Reports a hit for the indexed line and writes a line on fill or update

`timescale 1ns/1ps

module cache_way
    import cache_parameters::*;
(
    input  logic         clk,
    input  logic         reset,
    input  cache_index_t index,
    input  cache_tag_t   tag,
    input  cache_word_t  write_word,
    input  logic         fill,
    input  logic         update,
    output logic         hit,
    output cache_word_t  read_word,
    output logic         valid_line
);

    logic [NUM_SETS-1:0] valid_q;
    cache_tag_t          tag_q  [NUM_SETS];
    cache_word_t         data_q [NUM_SETS];

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;                                          // Whole way starts empty
        end else if (fill) begin
            valid_q[index] <= 1'b1;
        end
    end

    // A fill loads a new line and an update only rewrites the word
    always_ff @(posedge clk) begin
        if (fill) begin
            tag_q[index]  <= tag;
            data_q[index] <= write_word;
        end else if (update) begin
            data_q[index] <= write_word;
        end
    end

    assign valid_line = valid_q[index];
    assign hit        = valid_q[index] && (tag_q[index] == tag);
    assign read_word  = data_q[index];

    // The controller only asks for an update after a lookup that hit in this way
    update_only_on_hit: assert property (
        @(posedge clk) disable iff (reset) update |-> hit
    );

endmodule

// File: hw/cache_ctrl_if.sv
// Cache control link
// Commands from the cache controller to the datapath and the lookup status
// that the datapath returns for the registered request

`timescale 1ns/1ps

interface cache_ctrl_if
    import cache_parameters::*;
();

    // Commands
    logic     capture_req;                                          // Register the processor request
    logic     fill_en;                                              // Write the fetched word into the victim
    logic     update_en;                                            // Rewrite the hit line with the write data
    logic     lru_touch;

    // Status
    logic     hit;
    logic     req_write;
    way_sel_t hit_way;

    modport controller (
        output capture_req, fill_en, update_en, lru_touch,
        input  hit, req_write, hit_way
    );

    modport datapath (
        input  capture_req, fill_en, update_en, lru_touch,
        output hit, req_write, hit_way
    );

endinterface

// File: hw/axi4lite_parameters.sv
// AXI4-Lite parameters
// Address and data widths of the memory port and their vector types

package axi4lite_parameters;

    localparam int AXI_ADDR_WIDTH = 32;
    localparam int AXI_DATA_WIDTH = 32;                             // Single beat, one cache line

    typedef logic [AXI_ADDR_WIDTH-1:0] axi_addr_t;
    typedef logic [AXI_DATA_WIDTH-1:0] axi_data_t;

endpackage

// File: hw/cache_parameters.sv
// Cache parameters
// Geometry of the two-way set-associative data cache, the types for the
// fields of a processor address and the states of the cache controller FSM

package cache_parameters;

    localparam int ADDR_BITS   = 32;
    localparam int WORD_BITS   = 32;
    localparam int NUM_WAYS    = 2;
    localparam int NUM_SETS    = 16;
    localparam int OFFSET_BITS = 2;                                 // Byte offset within a word
    localparam int INDEX_BITS  = 4;
    localparam int TAG_BITS    = ADDR_BITS - INDEX_BITS - OFFSET_BITS;

    // Processor byte address and data word
    typedef logic [ADDR_BITS-1:0]  cache_addr_t;
    typedef logic [WORD_BITS-1:0]  cache_word_t;

    // Fields taken from the registered request address
    typedef logic [INDEX_BITS-1:0] cache_index_t;
    typedef logic [TAG_BITS-1:0]   cache_tag_t;

    typedef logic [NUM_WAYS-1:0]   way_sel_t;                       // One-hot, one bit per way

    // IDLE accepts a request and COMPARE looks it up.
    // The READ states fetch a missed word, the WRITE states carry a write to memory,
    // and RESPOND ends every request with a one-cycle valid
    typedef enum logic [2:0] {
        IDLE,
        COMPARE,
        READ_ADDR,
        READ_DATA,
        WRITE_REQ,
        WRITE_RESP,
        RESPOND
    } cache_state_e;

endpackage
